// File: arbiter/holdTimer.sv
module holdTimer
  import nocFlitPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    load,
  input  pktLen_t length,
  input  logic    step,
  input  logic    active,
  output logic    timesUp
);

  pktLen_t count;  // flits of the packet transferred so far.
  pktLen_t limit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else if (!active)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= pktLen_t'(1);  // header counts as the first flit.
      limit <= length;
    end
    else if (step)
    begin
      count <= count + pktLen_t'(1);
    end
  end

  // zero count means no header seen yet.
  assign timesUp = (count != '0) && (count == limit);

endmodule

// File: arbiter/portArbiter.sv
module portArbiter
  import nocFlitPkg::*;
  import routerPortPkg::*;
(
  input  logic            clk,
  input  logic            rst,
  flitLinkIf.monitor      heads [NUM_PORTS],
  output portMask_t       grant,
  output portIdx_t        grantPort
);

  arbState_t state;
  arbState_t nextState;
  portMask_t grantReg;
  portMask_t hdrWait;
  portMask_t xfer;
  portMask_t timesUp;
  portMask_t holding;
  portIdx_t  afterPort;

  function automatic arbState_t portState(portIdx_t port);
    arbState_t st;
    case (port)
      PORT_L:  st = ARB_L;
      PORT_N:  st = ARB_N;
      PORT_E:  st = ARB_E;
      PORT_W:  st = ARB_W;
      PORT_S:  st = ARB_S;
      default: st = ARB_IDLE;
    endcase
    return st;
  endfunction

  function automatic portIdx_t statePort(arbState_t st);
    portIdx_t port;
    case (st)
      ARB_N:   port = PORT_N;
      ARB_E:   port = PORT_E;
      ARB_W:   port = PORT_W;
      ARB_S:   port = PORT_S;
      default: port = PORT_L;
    endcase
    return port;
  endfunction

  // first waiting header in cyclic order starting at first.
  function automatic arbState_t pickNext(portMask_t req, portIdx_t first);
    arbState_t pick;
    int        pos;
    pick = ARB_IDLE;
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      pos = int'(first) + k;
      if (pos >= NUM_PORTS)
      begin
        pos = pos - NUM_PORTS;
      end
      if (req[pos])
      begin
        pick = portState(portIdx_t'(pos));
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gPort
    assign hdrWait[p] = heads[p].valid && isHeader(heads[p].flitId);
    assign xfer[p]    = heads[p].valid && heads[p].ready;

    holdTimer uTimer (
      .clk     (clk),
      .rst     (rst),
      .load    (xfer[p] && isHeader(heads[p].flitId)),
      .length  (headerLength(heads[p].data)),
      .step    (xfer[p] && isBody(heads[p].flitId)),
      .active  (holding[p]),
      .timesUp (timesUp[p])
    );
  end

  // grant drops in the cycle after the last flit so the next header waits.
  assign holding = grantReg & ~timesUp;
  assign grant   = holding;

  assign afterPort = (grantPort == PORT_S) ? PORT_L : grantPort + portIdx_t'(1);

  always_comb
  begin
    nextState = state;
    if (state == ARB_IDLE)
    begin
      nextState = pickNext(hdrWait, PORT_L);  // idle order L, N, E, W, S.
    end
    else if (timesUp[grantPort])
    begin
      nextState = pickNext(hdrWait, afterPort);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= ARB_IDLE;
      grantReg  <= '0;
      grantPort <= PORT_L;
    end
    else
    begin
      state    <= nextState;
      grantReg <= '0;
      if (nextState != ARB_IDLE)
      begin
        grantReg[statePort(nextState)] <= 1'b1;
        grantPort                      <= statePort(nextState);
      end
    end
  end

endmodule

// File: common/flitLinkIf.sv
interface flitLinkIf
  import nocFlitPkg::*;
();

  logic      valid;
  logic      ready;
  flitId_t   flitId;
  flitData_t data;

  modport source (
    output valid,
    output flitId,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  flitId,
    input  data,
    output ready
  );

  modport monitor (
    input valid,
    input ready,
    input flitId,
    input data
  );

endinterface

// File: common/nocFlitPkg.sv
package nocFlitPkg;

  localparam int FLIT_ID_W   = 3;
  localparam int FLIT_DATA_W = 16;
  localparam int PKT_LEN_W   = 12;

  typedef logic [FLIT_ID_W-1:0]   flitId_t;
  typedef logic [FLIT_DATA_W-1:0] flitData_t;
  typedef logic [PKT_LEN_W-1:0]   pktLen_t;

  // flit kinds seen on every link.
  localparam flitId_t FLIT_HEADER = 3'd1;
  localparam flitId_t FLIT_BODY   = 3'd2;

  // header data carries the packet length, header flit included.
  function automatic pktLen_t headerLength(flitData_t data);
    return data[PKT_LEN_W-1:0];
  endfunction

  function automatic logic isHeader(flitId_t flitId);
    return flitId == FLIT_HEADER;
  endfunction

  function automatic logic isBody(flitId_t flitId);
    return flitId == FLIT_BODY;
  endfunction

  // builds header data from a length, upper bits zero.
  function automatic flitData_t headerData(pktLen_t length);
    flitData_t data;
    data = '0;
    data[PKT_LEN_W-1:0] = length;
    return data;
  endfunction

endpackage

// File: common/routerPortPkg.sv
package routerPortPkg;

  localparam int NUM_PORTS  = 5;
  localparam int PORT_IDX_W = 3;

  typedef logic [PORT_IDX_W-1:0] portIdx_t;
  typedef logic [NUM_PORTS-1:0]  portMask_t;  // indexed by portIdx_t.

  localparam portIdx_t PORT_L = 3'd0;
  localparam portIdx_t PORT_N = 3'd1;
  localparam portIdx_t PORT_E = 3'd2;
  localparam portIdx_t PORT_W = 3'd3;
  localparam portIdx_t PORT_S = 3'd4;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_L,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S
  } arbState_t;

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  typedef logic [QUEUE_PTR_W-1:0] queuePtr_t;
  typedef logic [QUEUE_PTR_W:0]   queueCnt_t;  // one extra bit for full.

endpackage

// File: hdl/inputQueue.sv
module inputQueue
  import nocFlitPkg::*;
  import routerPortPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      inValid,
  output logic      inReady,
  input  flitId_t   inFlitId,
  input  flitData_t inData,
  flitLinkIf.source head
);

  flitId_t   idMem   [QUEUE_DEPTH];
  flitData_t dataMem [QUEUE_DEPTH];

  queuePtr_t wrPtr;
  queuePtr_t rdPtr;
  queueCnt_t count;
  queueCnt_t countNext;
  logic      push;
  logic      pop;

  assign push = inValid && inReady;
  assign pop  = head.valid && head.ready;

  assign head.valid  = (count != '0);
  assign head.flitId = idMem[rdPtr];
  assign head.data   = dataMem[rdPtr];

  assign countNext = count + queueCnt_t'(push) - queueCnt_t'(pop);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      inReady <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + queuePtr_t'(1);  // wraps at depth.
      end
      if (pop)
      begin
        rdPtr <= rdPtr + queuePtr_t'(1);
      end
      count   <= countNext;
      inReady <= (countNext != queueCnt_t'(QUEUE_DEPTH));
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr]   <= inFlitId;
      dataMem[wrPtr] <= inData;
    end
  end

endmodule

// File: hdl/outputStage.sv
module outputStage
  import nocFlitPkg::*;
  import routerPortPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  flitLinkIf.sink   heads [NUM_PORTS],
  input  portMask_t grant,
  input  portIdx_t  grantPort,
  output logic      outValid,
  input  logic      outReady,
  output flitId_t   outFlitId,
  output flitData_t outData,
  output portIdx_t  outPort
);

  portMask_t headValid;
  flitId_t   headId   [NUM_PORTS];
  flitData_t headData [NUM_PORTS];
  logic      canLoad;
  logic      pop;

  assign canLoad = !outValid || outReady;  // register empty or draining.

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gLink
    assign headValid[p]   = heads[p].valid;
    assign headId[p]      = heads[p].flitId;
    assign headData[p]    = heads[p].data;
    assign heads[p].ready = grant[p] && canLoad;
  end

  assign pop = |(headValid & grant) && canLoad;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (canLoad)
    begin
      outValid <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      outFlitId <= headId[grantPort];
      outData   <= headData[grantPort];
      outPort   <= grantPort;
    end
  end

endmodule

// File: hdl/routerOutputPort.sv
module routerOutputPort
  import nocFlitPkg::*;
  import routerPortPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t inValid,
  output portMask_t inReady,
  input  flitId_t   inFlitId [NUM_PORTS],
  input  flitData_t inData   [NUM_PORTS],
  output logic      outValid,
  input  logic      outReady,
  output flitId_t   outFlitId,
  output flitData_t outData,
  output portIdx_t  outPort
);

  flitLinkIf headLink [NUM_PORTS] ();

  portMask_t grant;
  portIdx_t  grantPort;

  // one queue per input, index order L, N, E, W, S.
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gQueue
    inputQueue uQueue (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inReady  (inReady[p]),
      .inFlitId (inFlitId[p]),
      .inData   (inData[p]),
      .head     (headLink[p])
    );
  end

  portArbiter uArbiter (
    .clk       (clk),
    .rst       (rst),
    .heads     (headLink),
    .grant     (grant),
    .grantPort (grantPort)
  );

  outputStage uOutStage (
    .clk       (clk),
    .rst       (rst),
    .heads     (headLink),
    .grant     (grant),
    .grantPort (grantPort),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outPort   (outPort)
  );

endmodule

// File: sources.f
common/nocFlitPkg.sv
common/routerPortPkg.sv
common/flitLinkIf.sv
arbiter/holdTimer.sv
arbiter/portArbiter.sv
hdl/inputQueue.sv
hdl/outputStage.sv
hdl/routerOutputPort.sv
verification/clockGen.sv
verification/routerOutputPortTb.sv

// File: verification/clockGen.sv
module clockGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // released on a falling edge.
  end

  always #20 clk = ~clk;  // period 40.

endmodule

// File: verification/routerOutputPortTb.sv
module routerOutputPortTb
  import nocFlitPkg::*;
  import routerPortPkg::*;
();

  localparam int WAIT_LIMIT = 400;
  localparam int ORDER_BASE = 'h80;

  logic      clk;
  logic      rst;
  portMask_t inValid;
  portMask_t inReady;
  flitId_t   inFlitId [NUM_PORTS];
  flitData_t inData   [NUM_PORTS];
  logic      outValid;
  logic      outReady;
  flitId_t   outFlitId;
  flitData_t outData;
  portIdx_t  outPort;

  logic [15:0] patMem   [256];
  flitId_t     stimId   [NUM_PORTS][16];  // one packet per port and test.
  flitData_t   stimData [NUM_PORTS][16];
  int          stimLen  [NUM_PORTS];
  int          stimPos  [NUM_PORTS];  // flits taken by the DUT.
  flitId_t     recvId   [256];
  flitData_t   recvData [256];
  portIdx_t    recvPort [256];
  portIdx_t    expOrder [NUM_PORTS];
  int          recvCount;
  int          expTotal;
  int          expOrderCount;
  int          stallMode;  // 0 ready, 1 stalled, 2 random.
  int          errors;
  int          errStart;
  int          curTest;
  int          testCount;
  int          failCount;
  portIdx_t    lastPort;

  clockGen uClock (.*);

  routerOutputPort u_dut (.*);

  task automatic checkFlit(flitId_t gotId, flitData_t gotData, flitId_t expId,
                           flitData_t expData);
    if (gotId !== expId || gotData !== expData)
    begin
      $display("MISMATCH at %0t: flit id %0d data %h, expected id %0d data %h",
               $time, gotId, gotData, expId, expData);
      errors++;
    end
  endtask

  task automatic checkPort(portIdx_t got, portIdx_t exp, string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(pktLen_t got, pktLen_t exp, string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkLevel(logic got, logic exp, string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // inputs change on the falling edge, outputs are read there too.
  task automatic stepCycle();
    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inValid[p] = stimPos[p] < stimLen[p];
      if (inValid[p])
      begin
        inFlitId[p] = stimId[p][stimPos[p]];
        inData[p]   = stimData[p][stimPos[p]];
        stimPos[p] += int'(inReady[p]);  // taken at the next rising edge.
      end
    end
    case (stallMode)
      0:       outReady = 1'b1;
      1:       outReady = 1'b0;
      default: outReady = ($urandom % 4) != 0;
    endcase
    if (outValid && outReady && recvCount < 256)
    begin
      recvId[recvCount]   = outFlitId;
      recvData[recvCount] = outData;
      recvPort[recvCount] = outPort;
      recvCount++;
    end
  endtask

  task automatic waitFlits(int target);
    int cycles;
    cycles = 0;
    while (recvCount < target && cycles < WAIT_LIMIT)
    begin
      stepCycle();
      cycles++;
    end
    if (recvCount < target)
    begin
      $display("Timeout in test %0d: only %0d of %0d output flits arrived in %0d cycles",
               curTest, recvCount, target, cycles);
      errors++;
    end
  endtask

  task automatic startTest(int testId);
    int a;
    int p;
    curTest       = testId;
    errStart      = errors;
    recvCount     = 0;
    expTotal      = 0;
    expOrderCount = 0;
    for (p = 0; p < NUM_PORTS; p++)
    begin
      stimLen[p] = 0;
      stimPos[p] = 0;
    end
    for (a = 0; patMem[a] != 0; a += 4)
    begin
      if (patMem[a] == testId)
      begin
        p              = patMem[a + 1];
        lastPort       = portIdx_t'(p);
        stimLen[p]     = patMem[a + 2];
        expTotal      += stimLen[p];
        stimId[p][0]   = FLIT_HEADER;
        stimData[p][0] = flitData_t'(stimLen[p]);  // length in the low bits.
        for (int k = 1; k < stimLen[p]; k++)
        begin
          stimId[p][k]   = FLIT_BODY;
          stimData[p][k] = patMem[a + 3] + flitData_t'(k);
        end
      end
    end
    for (a = ORDER_BASE; patMem[a] != 0; a += patMem[a + 1] + 2)
    begin
      if (patMem[a] == testId)
      begin
        expOrderCount = patMem[a + 1];
        for (int k = 0; k < expOrderCount; k++)
          expOrder[k] = portIdx_t'(patMem[a + 2 + k]);
      end
    end
  endtask

  // splits the output stream into runs of one port, each run one whole packet.
  task automatic checkStream();
    int       i;
    int       start;
    int       orderPos;
    portIdx_t p;
    i        = 0;
    orderPos = 0;
    while (i < recvCount)
    begin
      start = i;
      p     = recvPort[i];
      while (i < recvCount && recvPort[i] == p)
        i++;
      checkCount(pktLen_t'(i - start), pktLen_t'(stimLen[p]), "packet length");
      for (int k = 0; k < i - start && k < stimLen[p]; k++)
        checkFlit(recvId[start + k], recvData[start + k], stimId[p][k], stimData[p][k]);
      if (orderPos < expOrderCount)
        checkPort(p, expOrder[orderPos], "packet order");
      orderPos++;
    end
  endtask

  task automatic finishTest(string name);
    waitFlits(expTotal);
    repeat (4) stepCycle();  // catches stray flits.
    checkCount(pktLen_t'(recvCount), pktLen_t'(expTotal), "flits received");
    checkStream();
    if (errors == errStart)
      $display("test %0d %s: passed", curTest, name);
    else
      $display("test %0d %s: failed with %0d errors", curTest, name, errors - errStart);
    failCount += int'(errors != errStart);
    testCount++;
  endtask

  initial
  begin
    int cycles;
    inValid  = '0;
    outReady = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inFlitId[p] = '0;
      inData[p]   = '0;
    end
    stallMode = 0;
    errors    = 0;
    testCount = 0;
    failCount = 0;
    void'($urandom(84));
    $readmemh("verification/routerPatterns.mem", patMem);
    if ($isunknown(patMem[0]))
    begin
      $display("The pattern file could not be read");
      errors++;
    end

    startTest(1);
    cycles = 0;
    @(posedge clk);
    while (rst && cycles < 20)
    begin
      @(negedge clk);
      checkLevel(outValid, 1'b0, "outValid during reset");
      checkLevel(|inReady, 1'b0, "inReady during reset");
      @(posedge clk);
      cycles++;
    end
    if (rst)
    begin
      $display("Reset was never released");
      errors++;
    end
    finishTest("reset and idle order");

    for (int t = 2; t <= 6; t++)
    begin
      startTest(t);
      finishTest("single packet");
    end

    startTest(7);
    stallMode = 1;
    repeat (16) stepCycle();  // every port loads behind the stalled output.
    stallMode = 0;
    finishTest("round-robin order");
    startTest(8);
    finishTest("second round");

    startTest(9);
    stallMode = 2;
    finishTest("packet atomicity");

    startTest(10);
    stallMode = 1;
    cycles    = 0;
    while (inReady[lastPort] && cycles < 40)
    begin
      stepCycle();
      cycles++;
    end
    if (inReady[lastPort])
    begin
      $display("inReady on port %0d never dropped while the output was stalled", lastPort);
      errors++;
    end
    checkCount(pktLen_t'(stimPos[lastPort]), pktLen_t'(QUEUE_DEPTH), "flits taken when stalled");
    stallMode = 0;
    finishTest("back-pressure");

    $display("tests passed %0d, failed %0d, errors %0d", testCount - failCount, failCount,
             errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: verification/routerPatterns.mem
// each record holds test  port  length  payloadBase in hex
// test 0 ends the records and the order lists at 0x80 (test  count  ports)
1 1 3 1100
1 3 2 1300
2 0 3 2000
3 1 1 3100
4 2 4 4200
5 3 6 5300
6 4 2 6400
7 0 5 7000
7 1 3 7100
7 2 4 7200
7 3 2 7300
7 4 6 7400
8 1 2 8100
8 4 3 8400
9 0 7 9000
9 1 3 9100
9 2 9 9200
9 3 5 9300
9 4 6 9400
a 0 1 a000
a 2 7 a200
0 0 0 0
@80
1 2 1 3
7 5 0 1 2 3 4
8 2 1 4
a 2 0 2
0 0
